// ==== uart_defs.svh ====
// ----------------------------------------------------------------------
// UART build-time constants
// FIFO sizing, oversampling ratio and register offsets
// ----------------------------------------------------------------------
`ifndef UART_DEFS_SVH
`define UART_DEFS_SVH

`define UART_FIFO_DEPTH 16
`define UART_FIFO_AW 4
`define UART_OVERSAMPLE 16

// Offset 0 is shared by RBR, THR and DLL
`define UART_ADDR_RBR 3'd0
`define UART_ADDR_DLM 3'd1
`define UART_ADDR_LCR 3'd3
`define UART_ADDR_MCR 3'd4
`define UART_ADDR_LSR 3'd5
`define UART_ADDR_SCR 3'd7

`endif

// ==== uartBusPkg.sv ====
// ----------------------------------------------------------------------
// Register bus types
// Bus request struct, register field types and the LSR layout
// ----------------------------------------------------------------------
package uartBusPkg;

	typedef logic [2:0] regAddr;
	typedef logic [7:0] regData;
	typedef logic [15:0] divisor;

	typedef struct packed {
		logic sel;
		logic enable;
		logic write;
		regAddr addr;
		regData wdata;
	} busReq;

	// Bit 7 down to bit 0
	typedef struct packed {
		logic fifoErr;
		logic temt;
		logic thre;
		logic bi;
		logic fe;
		logic pe;
		logic oe;
		logic dr;
	} lsrReg;

endpackage

// ==== uartLinePkg.sv ====
// ----------------------------------------------------------------------
// Serial line types
// Characters, line configuration, received words and FSM states
// ----------------------------------------------------------------------
package uartLinePkg;

	typedef logic [7:0] dataByte;
	typedef logic [3:0] tickCount;

	typedef struct packed {
		logic parityEn;
		logic evenParity;
	} lineCfg;

	// Entry of the receive FIFO, flags above the character
	typedef struct packed {
		logic fe;
		logic pe;
		dataByte data;
	} rxWord;

	typedef enum logic [2:0] {TX_IDLE, TX_START, TX_DATA, TX_PARITY, TX_STOP} txState;

	typedef enum logic [2:0] {RX_IDLE, RX_START, RX_DATA, RX_PARITY, RX_STOP} rxState;

endpackage

// ==== uartBaudGen.sv ====
// ----------------------------------------------------------------------
// Baud generator, one tick every div clocks (16x the bit rate)
// ----------------------------------------------------------------------
module uartBaudGen import uartBusPkg::*;
(
	input logic CLK,
	input logic iRST,
	input divisor div,
	output logic tick
);

	divisor count;

	// Reload on expiry, so a new divisor waits for the next reload
	always_ff @(posedge CLK or posedge iRST)
	begin
		if (iRST)
		begin
			count <= '0;
			tick <= 1'b0;
		end
		else if (div == '0)
		begin
			count <= '0;
			tick <= 1'b0;
		end
		else if (count <= divisor'(1))
		begin
			count <= div;
			tick <= 1'b1;
		end
		else
		begin
			count <= count - 1'b1;
			tick <= 1'b0;
		end
	end

endmodule

// ==== uartFifo.sv ====
// ----------------------------------------------------------------------
// Synchronous FIFO with occupancy counter
// ----------------------------------------------------------------------
`include "uart_defs.svh"

module uartFifo #(
	parameter int WIDTH = 8
)
(
	input logic CLK,
	input logic iRST,
	input logic push,
	input logic [WIDTH-1:0] pushData,
	input logic pop,
	output logic [WIDTH-1:0] head,
	output logic empty,
	output logic full
);

	logic [WIDTH-1:0] mem [`UART_FIFO_DEPTH];
	logic [`UART_FIFO_AW-1:0] wrPtr;
	logic [`UART_FIFO_AW-1:0] rdPtr;
	logic [`UART_FIFO_AW:0] count;
	logic doPush;
	logic doPop;

	// Push while full and pop while empty have no effect
	assign doPush = push && !full;
	assign doPop = pop && !empty;

	assign empty = count == '0;
	assign full = count == (`UART_FIFO_AW+1)'(`UART_FIFO_DEPTH);
	assign head = mem[rdPtr];

	always_ff @(posedge CLK)
	begin
		if (doPush)
			mem[wrPtr] <= pushData;
	end

	always_ff @(posedge CLK or posedge iRST)
	begin
		if (iRST)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= wrPtr + 1'b1;
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
			count <= count + doPush - doPop;
		end
	end

endmodule

// ==== uartRegs.sv ====
// ----------------------------------------------------------------------
// UART register file
// Bus decode, DLL/DLM/LCR/MCR/SCR storage, read mux and LSR flags
// ----------------------------------------------------------------------
`include "uart_defs.svh"

module uartRegs import uartBusPkg::*; import uartLinePkg::*;
(
	input logic CLK,
	input logic iRST,
	input busReq bus,
	output regData rdata,
	output logic txPush,
	output dataByte txData,
	input logic txEmpty,
	input logic txBusy,
	output logic rxPop,
	input rxWord rxHead,
	input logic rxEmpty,
	input logic rxFull,
	input logic rxPush,
	output divisor div,
	output lineCfg cfg,
	output logic loop
);

	logic busWrite;
	logic busRead;
	logic dlab;
	regData dll;
	regData dlm;
	regData lcr;
	regData scr;
	logic mcrLoop;
	logic overrun;
	lsrReg lsr;

	assign busWrite = bus.sel && bus.enable && bus.write;
	assign busRead = bus.sel && bus.enable && !bus.write;
	assign dlab = lcr[7];

	// Offset 0 is THR/RBR with DLAB clear
	assign txPush = busWrite && bus.addr == `UART_ADDR_RBR && !dlab;
	assign txData = bus.wdata;
	assign rxPop = busRead && bus.addr == `UART_ADDR_RBR && !dlab;

	assign div = {dlm, dll};
	assign cfg.parityEn = lcr[3];
	assign cfg.evenParity = lcr[4];
	assign loop = mcrLoop;

	always_ff @(posedge CLK or posedge iRST)
	begin
		if (iRST)
		begin
			dll <= '0;
			dlm <= '0;
			lcr <= '0;
			scr <= '0;
			mcrLoop <= 1'b0;
		end
		else if (busWrite)
		begin
			case (bus.addr)
				`UART_ADDR_RBR: if (dlab) dll <= bus.wdata;
				`UART_ADDR_DLM: if (dlab) dlm <= bus.wdata;
				`UART_ADDR_LCR: lcr <= bus.wdata;
				`UART_ADDR_MCR: mcrLoop <= bus.wdata[4];
				`UART_ADDR_SCR: scr <= bus.wdata;
				default: ;
			endcase
		end
	end

	// Sticky overrun, a new drop wins over the clearing read
	always_ff @(posedge CLK or posedge iRST)
	begin
		if (iRST)
			overrun <= 1'b0;
		else if (rxPush && rxFull)
			overrun <= 1'b1;
		else if (busRead && bus.addr == `UART_ADDR_LSR)
			overrun <= 1'b0;
	end

	assign lsr.fifoErr = 1'b0;
	assign lsr.temt = txEmpty && !txBusy;
	assign lsr.thre = txEmpty;
	assign lsr.bi = 1'b0;
	assign lsr.fe = !rxEmpty && rxHead.fe;
	assign lsr.pe = !rxEmpty && rxHead.pe;
	assign lsr.oe = overrun;
	assign lsr.dr = !rxEmpty;

	always_comb
	begin
		case (bus.addr)
			`UART_ADDR_RBR: rdata = dlab ? dll : rxHead.data;
			`UART_ADDR_DLM: rdata = dlab ? dlm : '0;
			`UART_ADDR_LCR: rdata = lcr;
			`UART_ADDR_MCR: rdata = {3'b000, mcrLoop, 4'b0000};
			`UART_ADDR_LSR: rdata = lsr;
			`UART_ADDR_SCR: rdata = scr;
			default: rdata = '0;
		endcase
	end

endmodule

// ==== uartTransmitter.sv ====
// ----------------------------------------------------------------------
// UART transmitter
// Pops the TX FIFO and sends start, 8 data, optional parity and stop
// ----------------------------------------------------------------------
`include "uart_defs.svh"

module uartTransmitter import uartLinePkg::*;
(
	input logic CLK,
	input logic iRST,
	input logic tick,
	input lineCfg cfg,
	input logic fifoEmpty,
	input dataByte fifoHead,
	output logic fifoPop,
	output logic busy,
	output logic txBit
);

	localparam tickCount LAST_TICK = tickCount'(`UART_OVERSAMPLE - 1);

	txState state;
	tickCount tickCnt;
	logic [2:0] bitCnt;
	dataByte shiftReg;
	logic parityBit;

	assign fifoPop = tick && state == TX_IDLE && !fifoEmpty;
	assign busy = state != TX_IDLE;

	always_ff @(posedge CLK or posedge iRST)
	begin
		if (iRST)
		begin
			state <= TX_IDLE;
			tickCnt <= '0;
			bitCnt <= '0;
		end
		else if (tick)
		begin
			// Counter wraps at the end of every bit
			tickCnt <= tickCnt + 1'b1;
			case (state)
				TX_IDLE:
				begin
					tickCnt <= '0;
					if (!fifoEmpty)
						state <= TX_START;
				end
				TX_START:
				begin
					bitCnt <= '0;
					if (tickCnt == LAST_TICK)
						state <= TX_DATA;
				end
				TX_DATA:
				begin
					if (tickCnt == LAST_TICK)
					begin
						bitCnt <= bitCnt + 1'b1;
						if (bitCnt == 3'd7)
							state <= cfg.parityEn ? TX_PARITY : TX_STOP;
					end
				end
				TX_PARITY: if (tickCnt == LAST_TICK) state <= TX_STOP;
				TX_STOP: if (tickCnt == LAST_TICK) state <= TX_IDLE;
				default: state <= TX_IDLE;
			endcase
		end
	end

	// Even parity is the XOR of the data, odd parity its inverse
	always_ff @(posedge CLK)
	begin
		if (fifoPop)
		begin
			shiftReg <= fifoHead;
			parityBit <= ^fifoHead ^ !cfg.evenParity;
		end
		else if (tick && state == TX_DATA && tickCnt == LAST_TICK)
			shiftReg <= shiftReg >> 1;
	end

	always_comb
	begin
		case (state)
			TX_START: txBit = 1'b0;
			TX_DATA: txBit = shiftReg[0];
			TX_PARITY: txBit = parityBit;
			default: txBit = 1'b1;
		endcase
	end

endmodule

// ==== uartReceiver.sv ====
// ----------------------------------------------------------------------
// UART receiver
// Input synchronizer, start detection, mid-bit sampling, word push
// ----------------------------------------------------------------------
`include "uart_defs.svh"

module uartReceiver import uartLinePkg::*;
(
	input logic CLK,
	input logic iRST,
	input logic tick,
	input lineCfg cfg,
	input logic rxLine,
	output logic push,
	output rxWord word
);

	localparam tickCount LAST_TICK = tickCount'(`UART_OVERSAMPLE - 1);
	localparam tickCount HALF_TICK = tickCount'(`UART_OVERSAMPLE / 2 - 1);

	logic [1:0] rxSync;
	logic line;
	rxState state;
	tickCount tickCnt;
	logic [2:0] bitCnt;
	dataByte shiftReg;
	logic parityAcc;
	logic bitEnd;

	// Two flops against metastability, idle level is high
	always_ff @(posedge CLK or posedge iRST)
	begin
		if (iRST)
			rxSync <= 2'b11;
		else
			rxSync <= {rxSync[0], rxLine};
	end

	assign line = rxSync[1];
	assign bitEnd = tick && tickCnt == LAST_TICK;

	always_ff @(posedge CLK or posedge iRST)
	begin
		if (iRST)
		begin
			state <= RX_IDLE;
			tickCnt <= '0;
			bitCnt <= '0;
			push <= 1'b0;
		end
		else
		begin
			push <= 1'b0;
			if (tick)
			begin
				tickCnt <= tickCnt + 1'b1;
				case (state)
					RX_IDLE:
					begin
						tickCnt <= '0;
						if (!line)
							state <= RX_START;
					end
					RX_START:
					begin
						// Still low half a bit later, so the frame is real
						if (tickCnt == HALF_TICK)
						begin
							tickCnt <= '0;
							bitCnt <= '0;
							state <= line ? RX_IDLE : RX_DATA;
						end
					end
					RX_DATA:
					begin
						if (tickCnt == LAST_TICK)
						begin
							bitCnt <= bitCnt + 1'b1;
							if (bitCnt == 3'd7)
								state <= cfg.parityEn ? RX_PARITY : RX_STOP;
						end
					end
					RX_PARITY: if (tickCnt == LAST_TICK) state <= RX_STOP;
					RX_STOP:
					begin
						if (tickCnt == LAST_TICK)
						begin
							push <= 1'b1;
							state <= RX_IDLE;
						end
					end
					default: state <= RX_IDLE;
				endcase
			end
		end
	end

	// Accumulated parity covers data and parity bit
	always_ff @(posedge CLK)
	begin
		if (tick && state == RX_START)
			parityAcc <= 1'b0;
		else if (bitEnd && (state == RX_DATA || state == RX_PARITY))
			parityAcc <= parityAcc ^ line;
		if (bitEnd && state == RX_DATA)
			shiftReg <= {line, shiftReg[7:1]};
		if (bitEnd && state == RX_STOP)
		begin
			word.data <= shiftReg;
			word.fe <= !line;
			word.pe <= cfg.parityEn && (parityAcc == cfg.evenParity);
		end
	end

endmodule

// ==== uartTop.sv ====
// ----------------------------------------------------------------------
// UART top level
// Block instances, loopback muxes and serial output
// ----------------------------------------------------------------------
module uartTop import uartBusPkg::*; import uartLinePkg::*;
(
	input logic CLK,
	input logic iRST,
	input busReq bus,
	output regData rdata,
	input logic sin,
	output logic sout
);

	divisor div;
	lineCfg cfg;
	logic tick;
	logic loop;
	logic txPush;
	dataByte txData;
	dataByte txHead;
	logic txPop;
	logic txEmpty;
	logic txFull;
	logic txBusy;
	logic txBit;
	logic rxPush;
	logic rxPop;
	rxWord rxIn;
	rxWord rxHead;
	logic rxEmpty;
	logic rxFull;
	logic rxLine;

	// Loopback feeds the receiver and parks the line high
	assign rxLine = loop ? txBit : sin;
	assign sout = loop ? 1'b1 : txBit;

	uartRegs uartRegs_i (
		.CLK(CLK), .iRST(iRST), .bus(bus), .rdata(rdata),
		.txPush(txPush), .txData(txData), .txEmpty(txEmpty), .txBusy(txBusy),
		.rxPop(rxPop), .rxHead(rxHead), .rxEmpty(rxEmpty), .rxFull(rxFull),
		.rxPush(rxPush), .div(div), .cfg(cfg), .loop(loop)
	);

	uartBaudGen uartBaudGen_i (.CLK(CLK), .iRST(iRST), .div(div), .tick(tick));

	uartFifo #(.WIDTH(8)) txFifo (
		.CLK(CLK), .iRST(iRST), .push(txPush), .pushData(txData),
		.pop(txPop), .head(txHead), .empty(txEmpty), .full(txFull)
	);

	uartFifo #(.WIDTH(10)) rxFifo (
		.CLK(CLK), .iRST(iRST), .push(rxPush), .pushData(rxIn),
		.pop(rxPop), .head(rxHead), .empty(rxEmpty), .full(rxFull)
	);

	uartTransmitter uartTransmitter_i (
		.CLK(CLK), .iRST(iRST), .tick(tick), .cfg(cfg), .fifoEmpty(txEmpty),
		.fifoHead(txHead), .fifoPop(txPop), .busy(txBusy), .txBit(txBit)
	);

	uartReceiver uartReceiver_i (
		.CLK(CLK), .iRST(iRST), .tick(tick), .cfg(cfg), .rxLine(rxLine),
		.push(rxPush), .word(rxIn)
	);

endmodule

// ==== tbUart_assert.sv ====
// ----------------------------------------------------------------------
// Concurrent assertions on the UART top level
// Idle serial output, LSR consistency and TX FIFO overflow
// ----------------------------------------------------------------------
`include "uart_defs.svh"

module tbUartAssert import uartBusPkg::*;
(
	input logic CLK,
	input logic iRST,
	input logic sout,
	input logic loop,
	input busReq bus,
	input regData rdata,
	input logic txFifoPush,
	input logic txFull
);

	timeunit 1ns;
	timeprecision 1ps;

	lsrReg lsrSeen;
	logic lsrRead;

	assign lsrSeen = rdata;
	assign lsrRead = bus.sel && bus.enable && !bus.write && bus.addr == `UART_ADDR_LSR;

	// Line stays parked high in reset and in loopback
	soutIdle: assert property (@(posedge CLK) (iRST || loop) |-> sout)
		else $error("sout low during reset or loopback");

	// LSR as seen on the bus never shows temt without thre
	temtThre: assert property (@(posedge CLK) disable iff (iRST)
		(lsrRead && lsrSeen.temt) |-> lsrSeen.thre)
		else $error("LSR temt set while thre clear");

	noPushFull: assert property (@(posedge CLK) disable iff (iRST)
		!(txFifoPush && txFull))
		else $error("push into a full transmit FIFO");

endmodule

// ==== tbUart.sv ====
// ----------------------------------------------------------------------
// UART testbench
// Clock and reset, bus tasks, serial driver and sampler, result checks
// Reset, register, loopback, receive, overrun and transmit tests
// ----------------------------------------------------------------------
`include "uart_defs.svh"

module tbUart import uartBusPkg::*; import uartLinePkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int DIV = 2;
	localparam int BIT_CLKS = `UART_OVERSAMPLE * DIV;
	localparam int POLL_LIMIT = 2000;
	localparam int EDGE_LIMIT = 4 * BIT_CLKS;

	logic CLK = 1'b0;
	logic iRST;
	busReq bus;
	regData rdata;
	logic sin;
	logic sout;

	int errors;
	int checks;
	int testErrors;
	dataByte expQ[$];

	uartTop uartTop_i (
		.CLK(CLK), .iRST(iRST), .bus(bus), .rdata(rdata), .sin(sin), .sout(sout)
	);

	bind uartTop tbUartAssert tbUartAssert_i (
		.CLK(CLK), .iRST(iRST), .sout(sout), .loop(loop), .bus(bus), .rdata(rdata),
		.txFifoPush(txPush), .txFull(txFull)
	);

	always #4 CLK = !CLK;

	task automatic busWrite(input regAddr addr, input regData data);
		@(negedge CLK);
		bus = '{sel: 1'b1, enable: 1'b1, write: 1'b1, addr: addr, wdata: data};
		@(negedge CLK);
		bus = '0;
	endtask

	// rdata is sampled mid low phase, the pop happens on the next edge
	task automatic busRead(input regAddr addr, output regData data);
		@(negedge CLK);
		bus = '{sel: 1'b1, enable: 1'b1, write: 1'b0, addr: addr, wdata: 8'h00};
		#1;
		data = rdata;
		@(negedge CLK);
		bus = '0;
	endtask

	task automatic checkReg(input string name, input regData got, input regData exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("error %s got 0x%02h expected 0x%02h", name, got, exp);
		end
	endtask

	task automatic checkLsr(input string name, input lsrReg got, input lsrReg exp,
		input lsrReg mask);
		checks++;
		if ((got & mask) !== (exp & mask))
		begin
			errors++;
			$display("error %s got 0x%02h expected 0x%02h mask 0x%02h", name, got, exp, mask);
		end
	endtask

	task automatic checkByte(input string name, input dataByte got, input dataByte exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("error %s got 0x%02h expected 0x%02h", name, got, exp);
		end
	endtask

	task automatic checkLine(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("error %s got 0x%0h expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic reportTimeout(input string what);
		errors++;
		$display("timeout while waiting for %s", what);
	endtask

	// Parity bit that makes the count of ones even or odd
	function automatic logic parityFor(dataByte data, logic even);
		int ones;
		ones = 0;
		for (int i = 0; i < 8; i++)
			if (data[i])
				ones++;
		return even ? (ones % 2 == 1) : (ones % 2 == 0);
	endfunction

	task automatic waitLsr(input lsrReg mask, input lsrReg value, input string what,
		output lsrReg seen);
		int polls;
		regData raw;
		polls = 0;
		do
		begin
			busRead(`UART_ADDR_LSR, raw);
			seen = raw;
			polls++;
		end
		while ((seen & mask) !== (value & mask) && polls < POLL_LIMIT);
		if ((seen & mask) !== (value & mask))
			reportTimeout(what);
	endtask

	// Zero divisor first so a stale large count cannot delay the reload
	task automatic setLine(input regData div, input logic parityEn, input logic even,
		input logic loopOn);
		busWrite(`UART_ADDR_LCR, 8'h80);
		busWrite(`UART_ADDR_DLM, 8'h00);
		busWrite(`UART_ADDR_RBR, 8'h00);
		busWrite(`UART_ADDR_RBR, div);
		busWrite(`UART_ADDR_LCR, {3'b000, even, parityEn, 3'b011});
		busWrite(`UART_ADDR_MCR, {3'b000, loopOn, 4'b0000});
	endtask

	task automatic driveBit(input logic value);
		@(negedge CLK);
		sin = value;
		repeat (BIT_CLKS - 1) @(negedge CLK);
	endtask

	task automatic sendFrame(input dataByte data, input logic parityEn, input logic even,
		input logic badParity, input logic badStop);
		driveBit(1'b0);
		for (int i = 0; i < 8; i++)
			driveBit(data[i]);
		if (parityEn)
			driveBit(parityFor(data, even) ^ badParity);
		driveBit(!badStop);
		// Idle gap lets the receiver drop a false start after a bad stop bit
		driveBit(1'b1);
		driveBit(1'b1);
	endtask

	task automatic receiveFrame(input logic parityEn, input logic even, output dataByte data);
		int polls;
		polls = 0;
		data = '0;
		while (sout !== 1'b0 && polls < EDGE_LIMIT)
		begin
			@(negedge CLK);
			polls++;
		end
		if (sout !== 1'b0)
		begin
			reportTimeout("start bit on sout");
			return;
		end
		repeat (BIT_CLKS / 2) @(negedge CLK);
		checkLine("sout start bit", sout, 1'b0);
		for (int i = 0; i < 8; i++)
		begin
			repeat (BIT_CLKS) @(negedge CLK);
			data[i] = sout;
		end
		if (parityEn)
		begin
			repeat (BIT_CLKS) @(negedge CLK);
			checkLine("sout parity bit", sout, parityFor(data, even));
		end
		repeat (BIT_CLKS) @(negedge CLK);
		checkLine("sout stop bit", sout, 1'b1);
	endtask

	task automatic endTest(input int num, input string name);
		if (errors == testErrors)
			$display("test %0d %s: ok", num, name);
		else
			$display("test %0d %s: %0d errors", num, name, errors - testErrors);
		testErrors = errors;
	endtask

	initial
	begin
		regData got;
		regData val;
		lsrReg lsr;
		dataByte rxByte;
		dataByte txBytes[6];
		logic pen;
		logic even;
		logic badPar;
		logic badStop;
		logic [1:0] kind;

		void'($urandom(32'h8107_eafd));
		errors = 0;
		checks = 0;
		testErrors = 0;
		bus = '0;
		sin = 1'b1;
		iRST = 1'b1;
		repeat (8) @(negedge CLK);
		iRST = 1'b0;

		busRead(`UART_ADDR_LSR, got);
		checkLsr("LSR", got, 8'h60, 8'hff);
		busRead(`UART_ADDR_LCR, got);
		checkReg("LCR", got, 8'h00);
		busRead(`UART_ADDR_SCR, got);
		checkReg("SCR", got, 8'h00);
		for (int i = 0; i < 32; i++)
		begin
			@(negedge CLK);
			checkLine("sout", sout, 1'b1);
		end
		endTest(1, "reset state");

		for (int i = 0; i < 4; i++)
		begin
			val = regData'($urandom());
			busWrite(`UART_ADDR_SCR, val);
			busRead(`UART_ADDR_SCR, got);
			checkReg("SCR", got, val);
			val = regData'($urandom());
			busWrite(`UART_ADDR_LCR, val);
			busRead(`UART_ADDR_LCR, got);
			checkReg("LCR", got, val);
			busWrite(`UART_ADDR_LCR, 8'h80);
			val = regData'($urandom());
			busWrite(`UART_ADDR_RBR, val);
			busRead(`UART_ADDR_RBR, got);
			checkReg("DLL", got, val);
			val = regData'($urandom());
			busWrite(`UART_ADDR_DLM, val);
			busRead(`UART_ADDR_DLM, got);
			checkReg("DLM", got, val);
		end
		busWrite(`UART_ADDR_DLM, 8'h00);
		busWrite(`UART_ADDR_RBR, 8'h00);
		busWrite(`UART_ADDR_LCR, 8'h00);
		busRead(3'd2, got);
		checkReg("offset 2", got, 8'h00);
		busRead(3'd6, got);
		checkReg("offset 6", got, 8'h00);
		endTest(2, "register readback");

		pen = 1'($urandom());
		even = 1'($urandom());
		setLine(regData'(DIV), pen, even, 1'b1);
		for (int i = 0; i < 8; i++)
		begin
			val = regData'($urandom());
			expQ.push_back(val);
			busWrite(`UART_ADDR_RBR, val);
		end
		for (int i = 0; i < 8; i++)
		begin
			waitLsr(8'h01, 8'h01, "loopback data ready", lsr);
			checkLsr("LSR", lsr, 8'h01, 8'h0f);
			busRead(`UART_ADDR_RBR, got);
			checkByte("RBR", got, expQ.pop_front());
		end
		waitLsr(8'h40, 8'h40, "loopback transmitter empty", lsr);
		endTest(3, "loopback");

		// Parity on so that wrong parity bits are detectable
		pen = 1'b1;
		even = 1'($urandom());
		setLine(regData'(DIV), pen, even, 1'b0);
		for (int i = 0; i < 12; i++)
		begin
			val = regData'($urandom());
			kind = 2'($urandom());
			badPar = kind == 2'd1;
			badStop = kind == 2'd2;
			expQ.push_back(val);
			sendFrame(val, pen, even, badPar, badStop);
			waitLsr(8'h01, 8'h01, "received data ready", lsr);
			checkLsr("LSR", lsr, {4'b0000, badStop, badPar, 2'b01}, 8'h0f);
			busRead(`UART_ADDR_RBR, got);
			checkByte("RBR", got, expQ.pop_front());
		end
		endTest(4, "external receive");

		for (int i = 0; i < 17; i++)
		begin
			val = regData'($urandom());
			if (i < `UART_FIFO_DEPTH)
				expQ.push_back(val);
			sendFrame(val, pen, even, 1'b0, 1'b0);
		end
		busRead(`UART_ADDR_LSR, got);
		checkLsr("LSR", got, 8'h03, 8'h0f);
		for (int i = 0; i < `UART_FIFO_DEPTH; i++)
		begin
			busRead(`UART_ADDR_RBR, got);
			checkByte("RBR", got, expQ.pop_front());
		end
		busRead(`UART_ADDR_LSR, got);
		checkLsr("LSR", got, 8'h60, 8'hff);
		endTest(5, "overrun");

		pen = 1'b1;
		even = 1'($urandom());
		setLine(regData'(DIV), pen, even, 1'b0);
		for (int i = 0; i < 6; i++)
		begin
			txBytes[i] = dataByte'($urandom());
			expQ.push_back(txBytes[i]);
		end
		fork
			begin
				for (int i = 0; i < 6; i++)
					busWrite(`UART_ADDR_RBR, txBytes[i]);
			end
			begin
				for (int i = 0; i < 6; i++)
				begin
					receiveFrame(pen, even, rxByte);
					checkByte("sout data", rxByte, expQ.pop_front());
				end
			end
		join
		// Still inside the last stop bit here
		busRead(`UART_ADDR_LSR, got);
		checkLsr("LSR", got, 8'h20, 8'h60);
		waitLsr(8'h40, 8'h40, "transmitter empty", lsr);
		checkLsr("LSR", lsr, 8'h60, 8'hff);
		checkLine("sout", sout, 1'b1);
		endTest(6, "transmit");

		$display("tests 6 checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// ==== uartTop.f ====
+incdir+.
uartBusPkg.sv
uartLinePkg.sv
uartBaudGen.sv
uartFifo.sv
uartRegs.sv
uartTransmitter.sv
uartReceiver.sv
uartTop.sv
tbUart_assert.sv
tbUart.sv

// ==== run.sh ====
#!/bin/sh
# Build the UART testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tbUart --Mdir obj_dir -o simUart -f uartTop.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/simUart > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
	exit 1
fi
exit 0
